//--- filelist.f
+incdir+tests
hw/csr_pkg.sv
hw/trap_pkg.sv
hw/csr_counters.sv
hw/irq_sampler.sv
hw/trap_fsm.sv
hw/csr_file.sv
hw/csr_unit.sv
tests/csr_unit_tb.sv

//--- Makefile
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
TOP        := csr_unit_tb
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
PASS_MSG   := Everything OK

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/csr_vectors.svh
// columns: name, operation, csr address, data, aux, expected value.
// exception rows carry the cause in the address, the pc in data and mtval in aux.
// pulse rows expect the cycles from stimulus to pulse, 0 for no pulse.
// interrupt rows: data bits 3..0 are irpt, meip, msip, mtip; aux is the next pc.

pattern = $random(seed);

// reset values and constants.
add_row("misa",              op_read,   csr_misa,     32'h0,        32'h0,        misa_value);
add_row("mhartid",           op_read,   csr_mhartid,  32'h0,        32'h0,        test_hart_id);
add_row("mstatus reset",     op_read,   csr_mstatus,  32'h0,        32'h0,        32'h0);
add_row("mie reset",         op_read,   csr_mie,      32'h0,        32'h0,        32'h0);
add_row("mcause reset",      op_read,   csr_mcause,   32'h0,        32'h0,        32'h0);

// writes and legalization.
add_row("mscratch write",    op_write,  csr_mscratch, pattern,      32'h0,        32'h0);
add_row("mscratch read",     op_read,   csr_mscratch, 32'h0,        32'h0,        pattern);
add_row("mtvec write",       op_write,  csr_mtvec,    32'h0000_1000, 32'h0,       32'h0);
add_row("mtvec read",        op_read,   csr_mtvec,    32'h0,        32'h0,        32'h0000_1000);
add_row("mpp m write",       op_write,  csr_mstatus,  32'h0000_1800, 32'h0,       32'h0);
add_row("mpp m read",        op_read,   csr_mstatus,  32'h0,        32'h0,        32'h0000_1800);
add_row("mpp 1 write",       op_write,  csr_mstatus,  32'h0000_0800, 32'h0,       32'h0);
add_row("mpp 1 ignored",     op_read,   csr_mstatus,  32'h0,        32'h0,        32'h0000_1800);
add_row("mie all ones",      op_write,  csr_mie,      32'hffff_ffff, 32'h0,       32'h0);
add_row("mie reserved",      op_read,   csr_mie,      32'h0,        32'h0,        32'h0000_0bbb);

// exception, then mret.
add_row("global mie on",     op_write,  csr_mstatus,  32'h0000_1808, 32'h0,       32'h0);
add_row("exception pulse",   op_exc,    12'h002,      32'h0000_0200, 32'hdead_beef, 32'd1);
add_row("exception mepc",    op_read,   csr_mepc,     32'h0,        32'h0,        32'h0000_0200);
add_row("exception mcause",  op_read,   csr_mcause,   32'h0,        32'h0,        32'h0000_0002);
add_row("exception mtval",   op_read,   csr_mtval,    32'h0,        32'h0,        32'hdead_beef);
add_row("mstatus trapped",   op_read,   csr_mstatus,  32'h0,        32'h0,        32'h0000_1880);
add_row("mret pulse",        op_mret,   12'h000,      32'h0,        32'h0,        32'd1);
add_row("mstatus returned",  op_read,   csr_mstatus,  32'h0,        32'h0,        32'h0000_1808);

// interrupts.
add_row("mie soft timer",    op_write,  csr_mie,      32'h0000_0088, 32'h0,       32'h0);
add_row("mtvec vectored",    op_write,  csr_mtvec,    32'h0000_2001, 32'h0,       32'h0);
add_row("irq pulse",         op_irq,    12'h000,      32'h0000_0003, 32'h0000_0340, 32'd2);
add_row("irq mcause",        op_read,   csr_mcause,   32'h0,        32'h0,        32'h8000_0003);
add_row("irq mepc",          op_read,   csr_mepc,     32'h0,        32'h0,        32'h0000_0340);
add_row("irq mepc out",      op_epc,    12'h000,      32'h0,        32'h0,        32'h0000_0340);
add_row("irq target",        op_target, 12'h000,      32'h0,        32'h0,        32'h0000_200c);
add_row("irq masked",        op_irq,    12'h000,      32'h0000_0003, 32'h0000_0340, 32'd0);

// counters.
add_row("mcycle first",      op_mark,   csr_mcycle,   32'h0,        32'h0,        32'h0);
add_row("idle",              op_idle,   12'h000,      32'd5,        32'h0,        32'h0);
add_row("mcycle delta",      op_delta,  csr_mcycle,   32'h0,        32'h0,        32'd6);
add_row("minstret first",    op_mark,   csr_minstret, 32'h0,        32'h0,        32'h0);
add_row("retire two",        op_retire, 12'h000,      32'd3,        32'h3,        32'h0);
add_row("retire one",        op_retire, 12'h000,      32'd2,        32'h1,        32'h0);
add_row("minstret delta",    op_delta,  csr_minstret, 32'h0,        32'h0,        32'd8);
add_row("mcycleh write",     op_write,  csr_mcycleh,  32'h0000_00a5, 32'h0,       32'h0);
add_row("mcycleh read",      op_read,   csr_mcycleh,  32'h0,        32'h0,        32'h0000_00a5);

// floating-point state field.
add_row("fs write",          op_write,  csr_mstatus,  32'h0000_3800, 32'h0,       32'h0);
add_row("fs out",            op_fs,     12'h000,      32'h0,        32'h0,        32'd1);

//--- tests/csr_unit_tb.sv
`default_nettype none

module csr_unit_tb
  import csr_pkg::*;
  import trap_pkg::*;
();

  localparam xlen_t test_hart_id = 32'h0000_0007;
  localparam int    half_period  = 20;
  localparam int    settle       = 10; // sample point after the falling edge.
  localparam int    window       = 4;  // cycles watched for a pulse.

  typedef enum logic [3:0] {
    op_read,
    op_write,
    op_exc,
    op_irq,
    op_mret,
    op_idle,
    op_target,
    op_mark,
    op_delta,
    op_retire,
    op_epc,
    op_fs
  } op_t;

  typedef struct packed {
    op_t       op;
    csr_addr_t addr;
    xlen_t     data;
    xlen_t     aux;
    xlen_t     want;
  } row_t;

  logic          clock;
  logic          reset;
  csr_read_t     csr_read;
  csr_write_t    csr_write;
  exception_in_t exc_in;
  logic          meip;
  logic          msip;
  logic          mtip;
  logic          irpt;
  counter_t      mtime;
  xlen_t         rdata;
  trap_out_t     out;

  string  names[$];
  row_t   rows[$];
  bit     loaded;
  integer seed;
  int     errors;
  xlen_t  last_read;

  csr_unit #(
    .hart_id (test_hart_id)
  ) dut_i (
    .clock     (clock),
    .reset     (reset),
    .read      (csr_read),
    .write     (csr_write),
    .exception (exc_in),
    .meip      (meip),
    .msip      (msip),
    .mtip      (mtip),
    .irpt      (irpt),
    .mtime     (mtime),
    .rdata     (rdata),
    .out       (out)
  );

  initial begin
    clock = 1'b0;
    forever #half_period clock = ~clock;
  end

  // ****************************************
  // table and stimulus
  // ****************************************
  task automatic add_row(input string name, input op_t op, input csr_addr_t addr,
                         input xlen_t data, input xlen_t aux, input xlen_t want);
    row_t r;
    r.op   = op;
    r.addr = addr;
    r.data = data;
    r.aux  = aux;
    r.want = want;
    names.push_back(name);
    rows.push_back(r);
  endtask

  task automatic load_table();
    xlen_t pattern;
    `include "csr_vectors.svh"
  endtask

  task automatic clear_inputs();
    csr_read  = '0;
    csr_write = '0;
    exc_in    = '0;
    meip      = 1'b0;
    msip      = 1'b0;
    mtip      = 1'b0;
    irpt      = 1'b0;
    mtime     = '0;
  endtask

  // inputs for cycle k of a row.
  task automatic drive_row(input row_t r, input int k);
    case (r.op)
      op_read, op_mark, op_delta: begin
        csr_read.en   = 1'b1;
        csr_read.addr = r.addr;
      end
      op_write: begin
        csr_write.en   = 1'b1;
        csr_write.addr = r.addr;
        csr_write.data = r.data;
      end
      op_exc: begin
        if (k == 0) begin
          exc_in.exc    = 1'b1;
          exc_in.ecause = r.addr[7:0];
          exc_in.epc    = r.data;
          exc_in.etval  = r.aux;
        end
      end
      op_mret: begin
        exc_in.mret = (k == 0);
      end
      op_irq: begin
        irpt          = r.data[3];
        meip          = r.data[2];
        msip          = r.data[1];
        mtip          = r.data[0];
        exc_in.valid0 = 1'b1; // keeps an instruction boundary open.
        exc_in.pc     = r.aux;
      end
      op_retire: begin
        exc_in.valid0 = r.aux[0];
        exc_in.valid1 = r.aux[1];
      end
      default: ;
    endcase
  endtask

  task automatic next_cycle(input row_t r, input int k);
    @(negedge clock);
    clear_inputs();
    drive_row(r, k);
    #settle;
  endtask

  // ****************************************
  // checks
  // ****************************************
  task automatic report(input string name, input xlen_t want, input xlen_t got);
    if (got !== want) begin
      $display("MISMATCH %s expected %h actual %h", name, want, got);
      errors++;
    end else begin
      $display("ok       %s", name);
    end
  endtask

  task automatic report_fault(input string name, input string what);
    $display("FAIL     %s: %s", name, what);
    errors++;
  endtask

  task automatic watch_pulse(input string name, input row_t r);
    int   k;
    int   first;
    int   count;
    logic pulse;
    first = 0;
    count = 0;
    for (k = 0; k < window; k++) begin
      next_cycle(r, k);
      pulse = (r.op == op_mret) ? out.mret : out.trap;
      if (pulse) begin
        if (count == 0) begin
          first = k;
        end
        count++;
      end
    end
    if (count > 1) begin
      report_fault(name, "pulse stayed high for more than one cycle");
    end else if (r.want == 0 && count != 0) begin
      report_fault(name, "pulse seen where none was due");
    end else begin
      report(name, r.want, xlen_t'(first));
    end
  endtask

  task automatic run_row(input string name, input row_t r);
    int k;
    case (r.op)
      op_read: begin
        next_cycle(r, 0);
        last_read = rdata;
        report(name, r.want, rdata);
      end
      op_mark: begin
        next_cycle(r, 0);
        last_read = rdata;
        $display("done     %s", name);
      end
      op_delta: begin
        next_cycle(r, 0);
        report(name, r.want, rdata - last_read);
      end
      op_target: begin
        next_cycle(r, 0);
        report(name, r.want, out.target);
      end
      op_epc: begin
        next_cycle(r, 0);
        report(name, r.want, out.mepc);
      end
      op_fs: begin
        next_cycle(r, 0);
        report(name, r.want, xlen_t'(out.fs));
      end
      op_exc, op_irq, op_mret: begin
        watch_pulse(name, r);
      end
      op_idle, op_retire: begin
        for (k = 0; k < r.data; k++) begin
          next_cycle(r, k);
        end
        $display("done     %s", name);
      end
      default: begin
        next_cycle(r, 0);
        $display("done     %s", name);
      end
    endcase
  endtask

  // ****************************************
  // main sequence and watchdog
  // ****************************************
  initial begin
    int i;
    seed      = 32'h9eb75649;
    errors    = 0;
    last_read = '0;
    reset     = 1'b0;
    clear_inputs();
    load_table();
    loaded = 1'b1;
    repeat (10) @(negedge clock);
    reset = 1'b1;
    for (i = 0; i < rows.size(); i++) begin
      run_row(names[i], rows[i]);
    end
    @(negedge clock);
    clear_inputs();
    $display("%0d tests, %0d failed", rows.size(), errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    wait (reset);
    repeat (rows.size() * 10) @(posedge clock);
    $display("timeout: the table did not finish within %0d cycles", rows.size() * 10);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/csr_unit.sv
`default_nettype none

module csr_unit
  import csr_pkg::*;
  import trap_pkg::*;
#(
  parameter xlen_t hart_id = 32'h0
) (
  input  wire logic          clock,
  input  wire logic          reset,
  input  wire csr_read_t     read,
  input  wire csr_write_t    write,
  input  wire exception_in_t exception,
  input  wire logic          meip,
  input  wire logic          msip,
  input  wire logic          mtip,
  input  wire logic          irpt,
  input  wire counter_t      mtime,   // reserved for a time csr.
  output xlen_t              rdata,
  output trap_out_t          out
);

  csr_status_t  status;
  mip_t         pending;
  irq_req_t     request;
  trap_update_t update;
  counter_t     mcycle;
  counter_t     minstret;
  logic         trap;
  logic         mret;
  xlen_t        mepc;
  xlen_t        target;
  logic [1:0]   fs;

  csr_counters u_counters (
    .clock    (clock),
    .reset    (reset),
    .write    (write),
    .valid0   (exception.valid0),
    .valid1   (exception.valid1),
    .mcycle   (mcycle),
    .minstret (minstret)
  );

  irq_sampler u_irq (
    .clock   (clock),
    .reset   (reset),
    .meip    (meip),
    .msip    (msip),
    .mtip    (mtip),
    .irpt    (irpt),
    .status  (status),
    .pending (pending),
    .request (request)
  );

  trap_fsm u_fsm (
    .clock     (clock),
    .reset     (reset),
    .exception (exception),
    .status    (status),
    .request   (request),
    .update    (update),
    .trap      (trap),
    .mret      (mret)
  );

  csr_file #(
    .hart_id (hart_id)
  ) u_file (
    .clock    (clock),
    .reset    (reset),
    .read     (read),
    .write    (write),
    .update   (update),
    .pending  (pending),
    .mcycle   (mcycle),
    .minstret (minstret),
    .rdata    (rdata),
    .status   (status),
    .mepc     (mepc),
    .target   (target),
    .fs       (fs)
  );

  assign out = '{trap: trap, mret: mret, mepc: mepc, target: target, fs: fs};

endmodule

`default_nettype wire

//--- hw/csr_file.sv
`default_nettype none

module csr_file
  import csr_pkg::*;
  import trap_pkg::*;
#(
  parameter xlen_t hart_id = 32'h0
) (
  input  wire logic         clock,
  input  wire logic         reset,
  input  wire csr_read_t    read,
  input  wire csr_write_t   write,
  input  wire trap_update_t update,
  input  wire mip_t         pending,
  input  wire counter_t     mcycle,
  input  wire counter_t     minstret,
  output xlen_t             rdata,
  output csr_status_t       status,
  output xlen_t             mepc,
  output xlen_t             target,
  output logic [1:0]        fs
);

  mstatus_t mstatus;
  mie_t     mie;
  mip_t     mip_sw;
  xlen_t    mtvec;
  xlen_t    mscratch;
  xlen_t    mcause;
  xlen_t    mtval;
  mip_t     mip_view;
  logic     sd;
  xlen_t    tvec_base;

  // reserved fields forced to zero; an illegal mpp keeps the old value.
  function automatic mstatus_t legal_mstatus(mstatus_t cur, xlen_t data);
    mstatus_t w;
    w       = mstatus_t'(data);
    w.sd    = 1'b0;
    w.wpri0 = '0;
    w.wpri1 = '0;
    w.wpri2 = 1'b0;
    w.wpri3 = 1'b0;
    if (w.mpp != m_mode && w.mpp != u_mode) begin
      w.mpp = cur.mpp;
    end
    return w;
  endfunction

  assign mip_view = mip_t'(pending | mip_sw);
  assign sd       = (mstatus.fs == 2'b11) | (mstatus.xs == 2'b11);

  // *************************************
  // control registers
  // *************************************
  always_ff @(posedge clock) begin
    if (!reset) begin
      mstatus <= '0;
      mie     <= '0;
      mip_sw  <= '0;
      mtvec   <= '0;
      mcause  <= '0;
    end else begin
      if (write.en) begin
        case (write.addr)
          csr_mstatus: mstatus <= legal_mstatus(mstatus, write.data);
          csr_mie:     mie <= mie_t'(write.data[11:0] & ie_mask);
          csr_mip:     mip_sw <= mip_t'(write.data[11:0] & mip_sw_mask);
          csr_mtvec:   mtvec <= {write.data[31:2], 1'b0, write.data[0]}; // direct or vectored.
          csr_mcause:  mcause <= write.data;
          default: ;
        endcase
      end
      // trap side overrides a same-cycle write.
      if (update.take) begin
        mstatus.mpie <= mstatus.mie;
        mstatus.mie  <= 1'b0;
        mcause       <= {update.interrupt, 23'h0, update.mcause};
      end else if (update.mret) begin
        mstatus.mie  <= mstatus.mpie;
        mstatus.mpie <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (write.en) begin
      case (write.addr)
        csr_mscratch: mscratch <= write.data;
        csr_mepc:     mepc <= {write.data[31:1], 1'b0};
        csr_mtval:    mtval <= write.data;
        default: ;
      endcase
    end
    if (update.take) begin
      mepc  <= update.mepc;
      mtval <= update.mtval;
    end
  end

  // *************************************
  // read mux
  // *************************************
  always_comb begin
    rdata = '0;
    if (read.en) begin
      case (read.addr)
        csr_misa:      rdata = misa_value;
        csr_mvendorid: rdata = '0;
        csr_marchid:   rdata = '0;
        csr_mimpid:    rdata = '0;
        csr_mhartid:   rdata = hart_id;
        csr_mstatus:   rdata = {sd, mstatus[30:0]};
        csr_mie:       rdata = {20'h0, mie};
        csr_mip:       rdata = {20'h0, mip_view};
        csr_mtvec:     rdata = mtvec;
        csr_mscratch:  rdata = mscratch;
        csr_mepc:      rdata = mepc;
        csr_mcause:    rdata = mcause;
        csr_mtval:     rdata = mtval;
        csr_mcycle:    rdata = mcycle[31:0];
        csr_mcycleh:   rdata = mcycle[63:32];
        csr_minstret:  rdata = minstret[31:0];
        csr_minstreth: rdata = minstret[63:32];
        default:       rdata = '0;
      endcase
    end
  end

  assign tvec_base = {mtvec[31:2], 2'b00};

  // vectored mode only applies to interrupts.
  always_comb begin
    if (mtvec[1:0] == 2'b01 && mcause[31]) begin
      target = tvec_base + {22'h0, mcause[7:0], 2'b00};
    end else begin
      target = tvec_base;
    end
  end

  assign status.global_mie = mstatus.mie;
  assign status.enable     = mie;
  assign status.mtvec      = mtvec;
  assign fs                = mstatus.fs;

endmodule

`default_nettype wire

//--- hw/trap_fsm.sv
`default_nettype none

module trap_fsm
  import csr_pkg::*;
  import trap_pkg::*;
(
  input  wire logic          clock,
  input  wire logic          reset,
  input  wire exception_in_t exception,
  input  wire csr_status_t   status,
  input  wire irq_req_t      request,
  output trap_update_t       update,
  output logic               trap,
  output logic               mret
);

  trap_state_t state;
  trap_state_t state_next;
  logic        retire;
  logic        take_irq;

  assign retire = exception.valid0 | exception.valid1;

  // interrupts are only taken on an instruction boundary.
  assign take_irq = request.pending & status.global_mie & retire;

  // *************************************
  // register update
  // *************************************
  always_comb begin
    update = '0;
    if (exception.exc) begin
      update.take   = 1'b1;
      update.mepc   = exception.epc;
      update.mcause = exception.ecause;
      update.mtval  = exception.etval;
    end else if (take_irq) begin
      update.take      = 1'b1;
      update.interrupt = 1'b1;
      update.mepc      = exception.pc;
      update.mcause    = request.cause;
      update.mtval     = '0;     // no trap value for interrupts.
    end else if (exception.mret) begin
      update.mret = 1'b1;
    end
  end

  // *************************************
  // state
  // *************************************
  // trapped and returned only last a cycle.
  always_comb begin
    if (update.take) begin
      state_next = trapped;
    end else if (update.mret) begin
      state_next = returned;
    end else begin
      state_next = run;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= run;
    end else begin
      state <= state_next;
    end
  end

  assign trap = (state == trapped);
  assign mret = (state == returned);

endmodule

`default_nettype wire

//--- hw/irq_sampler.sv
`default_nettype none

module irq_sampler
  import csr_pkg::*;
  import trap_pkg::*;
(
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire logic        meip,
  input  wire logic        msip,
  input  wire logic        mtip,
  input  wire logic        irpt,
  input  wire csr_status_t status,
  output mip_t             pending,
  output irq_req_t         request
);

  // machine pending bits only; the s and u bits live in csr_file.
  always_ff @(posedge clock) begin
    if (!reset) begin
      pending <= '0;
    end else begin
      pending      <= '0;
      pending.meip <= meip | irpt; // board pin shares the external cause.
      pending.msip <= msip;
      pending.mtip <= mtip;
    end
  end

  // *************************************
  // priority: external, software, timer
  // *************************************
  always_comb begin
    request = '0;
    if (pending.meip && status.enable.meie) begin
      request.pending = 1'b1;
      request.cause   = irq_m_extern;
    end else if (pending.msip && status.enable.msie) begin
      request.pending = 1'b1;
      request.cause   = irq_m_soft;
    end else if (pending.mtip && status.enable.mtie) begin
      request.pending = 1'b1;
      request.cause   = irq_m_timer;
    end
  end

endmodule

`default_nettype wire

//--- hw/csr_counters.sv
`default_nettype none

module csr_counters
  import csr_pkg::*;
(
  input  wire logic       clock,
  input  wire logic       reset,
  input  wire csr_write_t write,
  input  wire logic       valid0,
  input  wire logic       valid1,
  output counter_t        mcycle,
  output counter_t        minstret
);

  logic     cycle_lo_wr;
  logic     cycle_hi_wr;
  logic     instret_lo_wr;
  logic     instret_hi_wr;
  counter_t retired;

  // a written half replaces the increment for that cycle.
  function automatic counter_t next_count(counter_t cur, logic wr_lo, logic wr_hi,
                                          xlen_t data, counter_t inc);
    counter_t nxt;
    nxt = cur + inc;
    if (wr_lo) begin
      nxt = {cur[63:32], data};
    end else if (wr_hi) begin
      nxt = {data, cur[31:0]};
    end
    return nxt;
  endfunction

  assign cycle_lo_wr   = write.en && (write.addr == csr_mcycle);
  assign cycle_hi_wr   = write.en && (write.addr == csr_mcycleh);
  assign instret_lo_wr = write.en && (write.addr == csr_minstret);
  assign instret_hi_wr = write.en && (write.addr == csr_minstreth);

  assign retired = counter_t'(valid0) + counter_t'(valid1); // 0, 1 or 2.

  always_ff @(posedge clock) begin
    if (!reset) begin
      mcycle   <= '0;
      minstret <= '0;
    end else begin
      mcycle   <= next_count(mcycle, cycle_lo_wr, cycle_hi_wr, write.data, counter_t'(1));
      minstret <= next_count(minstret, instret_lo_wr, instret_hi_wr, write.data, retired);
    end
  end

endmodule

`default_nettype wire

//--- hw/trap_pkg.sv
`default_nettype none

package trap_pkg;

  import csr_pkg::*;

  typedef logic [7:0] cause_t;

  localparam cause_t irq_m_soft   = 8'd3;
  localparam cause_t irq_m_timer  = 8'd7;
  localparam cause_t irq_m_extern = 8'd11;

  // *************************************
  // pipeline side
  // *************************************
  typedef struct packed {
    logic   exc;    // synchronous exception.
    cause_t ecause;
    xlen_t  epc;
    xlen_t  etval;
    logic   mret;
    logic   valid0;
    logic   valid1;
    xlen_t  pc;     // next instruction, saved on interrupts.
  } exception_in_t;

  typedef struct packed {
    logic   pending;
    cause_t cause;
  } irq_req_t;

  typedef struct packed {
    logic   take;
    logic   interrupt;
    xlen_t  mepc;
    cause_t mcause;
    xlen_t  mtval;
    logic   mret;
  } trap_update_t;

  typedef enum logic [1:0] {
    run,
    trapped,
    returned
  } trap_state_t;

  typedef struct packed {
    logic       trap;
    logic       mret;
    xlen_t      mepc;
    xlen_t      target;
    logic [1:0] fs;
  } trap_out_t;

endpackage

`default_nettype wire

//--- hw/csr_pkg.sv
`default_nettype none

package csr_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [63:0] counter_t;
  typedef logic [1:0]  priv_t;

  localparam priv_t u_mode = 2'b00;
  localparam priv_t m_mode = 2'b11;

  // *************************************
  // machine csr addresses
  // *************************************
  localparam csr_addr_t csr_mstatus   = 12'h300;
  localparam csr_addr_t csr_misa      = 12'h301;
  localparam csr_addr_t csr_mie       = 12'h304;
  localparam csr_addr_t csr_mtvec     = 12'h305;
  localparam csr_addr_t csr_mscratch  = 12'h340;
  localparam csr_addr_t csr_mepc      = 12'h341;
  localparam csr_addr_t csr_mcause    = 12'h342;
  localparam csr_addr_t csr_mtval     = 12'h343;
  localparam csr_addr_t csr_mip       = 12'h344;
  localparam csr_addr_t csr_mcycle    = 12'hb00;
  localparam csr_addr_t csr_minstret  = 12'hb02;
  localparam csr_addr_t csr_mcycleh   = 12'hb80;
  localparam csr_addr_t csr_minstreth = 12'hb82;
  localparam csr_addr_t csr_mvendorid = 12'hf11;
  localparam csr_addr_t csr_marchid   = 12'hf12;
  localparam csr_addr_t csr_mimpid    = 12'hf13;
  localparam csr_addr_t csr_mhartid   = 12'hf14;

  localparam xlen_t misa_value = 32'h40001124; // rv32 i, m, f, c.

  // writable bits of mie, and the software-owned bits of mip.
  localparam logic [11:0] ie_mask     = 12'hbbb;
  localparam logic [11:0] mip_sw_mask = 12'h333;

  // *************************************
  // register layouts
  // *************************************
  typedef struct packed {
    logic       sd;
    logic [7:0] wpri0;
    logic       tsr;
    logic       tw;
    logic       tvm;
    logic       mxr;
    logic       sum;
    logic       mprv;
    logic [1:0] xs;
    logic [1:0] fs;
    priv_t      mpp;
    logic [1:0] wpri1;
    logic       spp;
    logic       mpie;
    logic       wpri2;
    logic       spie;
    logic       upie;
    logic       mie;
    logic       wpri3;
    logic       sie;
    logic       uie;
  } mstatus_t;

  typedef struct packed {
    logic meie;
    logic wpri2;
    logic seie;
    logic ueie;
    logic mtie;
    logic wpri1;
    logic stie;
    logic utie;
    logic msie;
    logic wpri0;
    logic ssie;
    logic usie;
  } mie_t;

  typedef struct packed {
    logic meip;
    logic wpri2;
    logic seip;
    logic ueip;
    logic mtip;
    logic wpri1;
    logic stip;
    logic utip;
    logic msip;
    logic wpri0;
    logic ssip;
    logic usip;
  } mip_t;

  typedef struct packed {
    logic      en;
    csr_addr_t addr;
  } csr_read_t;

  typedef struct packed {
    logic      en;
    csr_addr_t addr;
    xlen_t     data;
  } csr_write_t;

  // what the trap logic needs to see of the register file.
  typedef struct packed {
    logic  global_mie;
    mie_t  enable;
    xlen_t mtvec;
  } csr_status_t;

endpackage

`default_nettype wire
